//--- hdl/glb_cfg_pkg.sv
`default_nettype none

package glb_cfg_pkg;

    // Buffer geometry
    localparam int NUM_BANK   = 8;
    localparam int BANK_WORDS = 16;
    localparam int DATA_W     = 32;
    localparam int NUM_WRPORT = 2;
    localparam int NUM_RDPORT = 2;
    localparam int NUM_PORT   = 4;

    localparam int ADDR_W     = 7;
    localparam int ROW_W      = 4;
    localparam int BANK_IDX_W = 3;
    // Ports 0-1 write, ports 2-3 read
    localparam int PORT_IDX_W = 2;

    typedef logic [NUM_BANK-1:0] bank_mask_t;

    typedef struct packed {
        bank_mask_t mask;
    } wr_cfg_t;

    typedef struct packed {
        logic       src;
        logic [6:0] spare;
    } rd_cfg_t;

    // Same configuration word, meaning set by the target port
    typedef union packed {
        wr_cfg_t wr;
        rd_cfg_t rd;
    } glb_cfg_u;

    typedef struct packed {
        logic [PORT_IDX_W-1:0] port;
        glb_cfg_u              cfg;
    } cfg_req_t;

    typedef struct packed {
        logic                  valid;
        logic [BANK_IDX_W-1:0] first_bank;
        logic [1:0]            log2_cnt;
        logic [ADDR_W-1:0]     wrap_mask;
    } port_map_t;

endpackage

`default_nettype wire

//--- hdl/glb_port_pkg.sv
`default_nettype none

package glb_port_pkg;

    import glb_cfg_pkg::*;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } wr_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    // One access into a single bank
    typedef struct packed {
        logic              we;
        logic [ROW_W-1:0]  row;
        logic [DATA_W-1:0] data;
        logic              rd_port;
    } bank_op_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
    } rd_rsp_t;

endpackage

`default_nettype wire

//--- hdl/glb_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module glb_cfg_regs
    import glb_cfg_pkg::*;
(
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              cfg_valid_i,
    output logic                             cfg_ready_o,
    input  wire cfg_req_t                    cfg_req_i,
    output port_map_t [NUM_WRPORT-1:0]       wr_map_o,
    output logic      [NUM_RDPORT-1:0]       rd_src_o,
    output logic      [NUM_RDPORT-1:0]       rd_cfg_ok_o,
    output logic      [NUM_WRPORT-1:0]       hwm_clr_o
);

    logic                  cfg_fire;
    bank_mask_t            mask;
    logic [BANK_IDX_W-1:0] first_bank;
    logic [BANK_IDX_W:0]   bank_cnt;
    logic [1:0]            cnt_log2;
    port_map_t             new_map;

    assign cfg_ready_o = 1'b1;
    assign cfg_fire    = cfg_valid_i & cfg_ready_o;
    assign mask        = cfg_req_i.cfg.wr.mask;

    // ==========================================================
    // Map derivation from the bank mask
    // ==========================================================
    always_comb begin
        first_bank = '0;
        bank_cnt   = '0;
        cnt_log2   = '0;
        // Downward scan leaves the lowest set bit
        for (int b = NUM_BANK - 1; b >= 0; b--) begin
            if (mask[b]) begin
                first_bank = BANK_IDX_W'(b);
            end
            bank_cnt = bank_cnt + {{BANK_IDX_W{1'b0}}, mask[b]};
        end
        for (int i = 0; i <= BANK_IDX_W; i++) begin
            if (bank_cnt[i]) begin
                cnt_log2 = 2'(i);
            end
        end
        new_map.valid      = |mask;
        new_map.first_bank = first_bank;
        new_map.log2_cnt   = cnt_log2;
        new_map.wrap_mask  = ADDR_W'((BANK_WORDS << cnt_log2) - 1);
    end

    // High-water mark clear, same cycle as the map write
    always_comb begin
        for (int w = 0; w < NUM_WRPORT; w++) begin
            hwm_clr_o[w] = cfg_fire && (cfg_req_i.port == PORT_IDX_W'(w));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_map_o    <= '0;
            rd_src_o    <= '0;
            rd_cfg_ok_o <= '0;
        end else if (cfg_fire) begin
            for (int w = 0; w < NUM_WRPORT; w++) begin
                if (cfg_req_i.port == PORT_IDX_W'(w)) begin
                    wr_map_o[w] <= new_map;
                end
            end
            for (int r = 0; r < NUM_RDPORT; r++) begin
                if (cfg_req_i.port == PORT_IDX_W'(NUM_WRPORT + r)) begin
                    rd_src_o[r]    <= cfg_req_i.cfg.rd.src;
                    rd_cfg_ok_o[r] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/glb_addr_map.sv
`timescale 1ns/1ps
`default_nettype none

module glb_addr_map
    import glb_cfg_pkg::*;
    import glb_port_pkg::*;
(
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire       [NUM_WRPORT-1:0]           wr_valid_i,
    input  wire wr_req_t [NUM_WRPORT-1:0]        wr_req_i,
    output logic      [NUM_WRPORT-1:0]           wr_ready_o,
    input  wire       [NUM_RDPORT-1:0]           rd_valid_i,
    input  wire rd_req_t [NUM_RDPORT-1:0]        rd_req_i,
    output logic      [NUM_RDPORT-1:0]           rd_ready_o,
    input  wire port_map_t [NUM_WRPORT-1:0]      wr_map_i,
    input  wire       [NUM_RDPORT-1:0]           rd_src_i,
    input  wire       [NUM_RDPORT-1:0]           rd_cfg_ok_i,
    input  wire       [NUM_WRPORT-1:0]           hwm_clr_i,
    input  wire       [NUM_RDPORT-1:0]           credit_ok_i,
    output logic [NUM_PORT-1:0][BANK_IDX_W-1:0]  port_bank_o,
    output logic      [NUM_PORT-1:0]             port_req_o,
    input  wire       [NUM_PORT-1:0]             port_grant_i,
    output logic [NUM_WRPORT-1:0][ROW_W-1:0]     wr_row_o,
    output logic [NUM_RDPORT-1:0][ROW_W-1:0]     rd_row_o
);

    logic [NUM_WRPORT-1:0][ADDR_W:0]   hwm_q;
    logic [NUM_WRPORT-1:0][ADDR_W:0]   wr_next;
    logic [NUM_WRPORT-1:0][ADDR_W-1:0] wr_addr;
    logic [NUM_RDPORT-1:0][ADDR_W-1:0] rd_addr;
    logic [NUM_RDPORT-1:0]             rd_below;

    // ==========================================================
    // Address decode and port ready
    // ==========================================================
    always_comb begin
        for (int w = 0; w < NUM_WRPORT; w++) begin
            wr_addr[w]     = wr_req_i[w].addr & wr_map_i[w].wrap_mask;
            wr_next[w]     = {1'b0, wr_addr[w]} + 1'b1;
            port_bank_o[w] = wr_map_i[w].first_bank + BANK_IDX_W'(wr_addr[w] >> ROW_W);
            wr_row_o[w]    = wr_addr[w][ROW_W-1:0];
            port_req_o[w]  = wr_valid_i[w] & wr_map_i[w].valid;
            wr_ready_o[w]  = wr_map_i[w].valid & port_grant_i[w];
        end
        // Reads decode through the map of their source write port
        for (int r = 0; r < NUM_RDPORT; r++) begin
            rd_addr[r]  = rd_req_i[r].addr & wr_map_i[rd_src_i[r]].wrap_mask;
            port_bank_o[NUM_WRPORT+r] = wr_map_i[rd_src_i[r]].first_bank
                                      + BANK_IDX_W'(rd_addr[r] >> ROW_W);
            rd_row_o[r] = rd_addr[r][ROW_W-1:0];
            rd_below[r] = {1'b0, rd_addr[r]} < hwm_q[rd_src_i[r]];
            // A blocked read must not hold the bank against the write it waits for
            port_req_o[NUM_WRPORT+r] = rd_valid_i[r] & rd_cfg_ok_i[r]
                                     & rd_below[r] & credit_ok_i[r];
            rd_ready_o[r] = rd_cfg_ok_i[r] & port_grant_i[NUM_WRPORT+r]
                          & rd_below[r] & credit_ok_i[r];
        end
    end

    // High-water marks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hwm_q <= '0;
        end else begin
            for (int w = 0; w < NUM_WRPORT; w++) begin
                if (hwm_clr_i[w]) begin
                    hwm_q[w] <= '0;
                end else if (wr_valid_i[w] && wr_ready_o[w] && (wr_next[w] > hwm_q[w])) begin
                    hwm_q[w] <= wr_next[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/glb_bank.sv
`timescale 1ns/1ps
`default_nettype none

module glb_bank
    import glb_cfg_pkg::*;
    import glb_port_pkg::*;
(
    input  wire                clk,
    input  wire                op_valid_i,
    input  wire bank_op_t      op_i,
    output logic [DATA_W-1:0]  rdata_o
);

    logic [DATA_W-1:0] mem [BANK_WORDS];

    // Single port, one access per cycle
    always_ff @(posedge clk) begin
        if (op_valid_i) begin
            if (op_i.we) begin
                mem[op_i.row] <= op_i.data;
            end else begin
                rdata_o <= mem[op_i.row];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/glb_bank_arb.sv
`timescale 1ns/1ps
`default_nettype none

module glb_bank_arb
    import glb_cfg_pkg::*;
    import glb_port_pkg::*;
(
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  [NUM_PORT-1:0][BANK_IDX_W-1:0]  port_bank_i,
    input  wire  [NUM_PORT-1:0]                  port_req_i,
    output logic [NUM_PORT-1:0]                  port_grant_o,
    input  wire  [NUM_WRPORT-1:0][ROW_W-1:0]     wr_row_i,
    input  wire  [NUM_RDPORT-1:0][ROW_W-1:0]     rd_row_i,
    input  wire  [NUM_WRPORT-1:0][DATA_W-1:0]    wr_data_i,
    input  wire  [NUM_RDPORT-1:0]                rd_fire_i,
    input  wire  [NUM_WRPORT-1:0]                wr_fire_i,
    output logic [NUM_RDPORT-1:0]                rsp_valid_o,
    output logic [NUM_RDPORT-1:0][DATA_W-1:0]    rsp_data_o
);

    bank_op_t [NUM_BANK-1:0]             op_d;
    bank_op_t [NUM_BANK-1:0]             op_q;
    logic     [NUM_BANK-1:0]             op_vld_d;
    logic     [NUM_BANK-1:0]             op_vld_q;
    logic     [NUM_BANK-1:0]             ret_vld_q;
    logic     [NUM_BANK-1:0]             ret_tag_q;
    logic     [NUM_BANK-1:0][DATA_W-1:0] bank_rdata;

    // ==========================================================
    // Fixed priority per bank, read ports first
    // ==========================================================
    always_comb begin
        logic [NUM_BANK-1:0] taken;
        int                  p;
        taken        = '0;
        port_grant_o = '0;
        for (int k = 0; k < NUM_PORT; k++) begin
            p = (k + NUM_WRPORT) % NUM_PORT;
            if (port_req_i[p] && !taken[port_bank_i[p]]) begin
                port_grant_o[p]       = 1'b1;
                taken[port_bank_i[p]] = 1'b1;
            end
        end
    end

    // Next bank op from the accepted transfers
    always_comb begin
        op_d     = op_q;
        op_vld_d = '0;
        for (int w = 0; w < NUM_WRPORT; w++) begin
            if (wr_fire_i[w]) begin
                op_vld_d[port_bank_i[w]] = 1'b1;
                op_d[port_bank_i[w]]     = '{we: 1'b1, row: wr_row_i[w],
                                             data: wr_data_i[w], rd_port: 1'b0};
            end
        end
        for (int r = 0; r < NUM_RDPORT; r++) begin
            if (rd_fire_i[r]) begin
                op_vld_d[port_bank_i[NUM_WRPORT+r]] = 1'b1;
                op_d[port_bank_i[NUM_WRPORT+r]]     = '{we: 1'b0, row: rd_row_i[r],
                                                        data: '0, rd_port: 1'(r)};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_vld_q  <= '0;
            ret_vld_q <= '0;
        end else begin
            op_vld_q <= op_vld_d;
            for (int b = 0; b < NUM_BANK; b++) begin
                ret_vld_q[b] <= op_vld_q[b] & ~op_q[b].we;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANK; b++) begin
            op_q[b]      <= op_d[b];
            ret_tag_q[b] <= op_q[b].rd_port;
        end
    end

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        glb_bank u_bank (
            .clk        (clk),
            .op_valid_i (op_vld_q[b]),
            .op_i       (op_q[b]),
            .rdata_o    (bank_rdata[b])
        );
    end

    // Read data back to the port named in the op tag
    always_comb begin
        rsp_valid_o = '0;
        rsp_data_o  = '0;
        for (int b = 0; b < NUM_BANK; b++) begin
            if (ret_vld_q[b]) begin
                rsp_valid_o[ret_tag_q[b]] = 1'b1;
                rsp_data_o[ret_tag_q[b]]  = bank_rdata[b];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/glb_rd_return.sv
`timescale 1ns/1ps
`default_nettype none

module glb_rd_return
    import glb_cfg_pkg::*;
    import glb_port_pkg::*;
(
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  [NUM_RDPORT-1:0]              rd_fire_i,
    input  wire  [NUM_RDPORT-1:0]              in_valid_i,
    input  wire  [NUM_RDPORT-1:0][DATA_W-1:0]  in_data_i,
    output logic [NUM_RDPORT-1:0]              credit_ok_o,
    output logic [NUM_RDPORT-1:0]              rsp_valid_o,
    input  wire  [NUM_RDPORT-1:0]              rsp_ready_i,
    output rd_rsp_t [NUM_RDPORT-1:0]           rsp_o
);

    for (genvar r = 0; r < NUM_RDPORT; r++) begin : g_port
        logic [DATA_W-1:0] buf_q [2];
        logic              wr_ptr_q;
        logic              rd_ptr_q;
        logic [1:0]        used_q;
        // In flight plus buffered, never above two
        logic [1:0]        crd_q;
        logic              pop;

        assign pop = rsp_valid_o[r] & rsp_ready_i[r];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr_q <= 1'b0;
                rd_ptr_q <= 1'b0;
                used_q   <= '0;
                crd_q    <= '0;
            end else begin
                if (in_valid_i[r]) begin
                    wr_ptr_q <= ~wr_ptr_q;
                end
                if (pop) begin
                    rd_ptr_q <= ~rd_ptr_q;
                end
                used_q <= used_q + 2'(in_valid_i[r]) - 2'(pop);
                crd_q  <= crd_q + 2'(rd_fire_i[r]) - 2'(pop);
            end
        end

        always_ff @(posedge clk) begin
            if (in_valid_i[r]) begin
                buf_q[wr_ptr_q] <= in_data_i[r];
            end
        end

        assign rsp_valid_o[r]  = (used_q != 2'd0);
        assign rsp_o[r].data   = buf_q[rd_ptr_q];
        assign credit_ok_o[r]  = (crd_q < 2'd2);
    end

endmodule

`default_nettype wire

//--- hdl/glb_top.sv
`timescale 1ns/1ps
`default_nettype none

module glb_top
    import glb_cfg_pkg::*;
    import glb_port_pkg::*;
(
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              cfg_valid_i,
    output logic                             cfg_ready_o,
    input  wire cfg_req_t                    cfg_req_i,
    input  wire  [NUM_WRPORT-1:0]            wr_valid_i,
    output logic [NUM_WRPORT-1:0]            wr_ready_o,
    input  wire wr_req_t [NUM_WRPORT-1:0]    wr_req_i,
    input  wire  [NUM_RDPORT-1:0]            rd_valid_i,
    output logic [NUM_RDPORT-1:0]            rd_ready_o,
    input  wire rd_req_t [NUM_RDPORT-1:0]    rd_req_i,
    output logic [NUM_RDPORT-1:0]            rsp_valid_o,
    input  wire  [NUM_RDPORT-1:0]            rsp_ready_i,
    output rd_rsp_t [NUM_RDPORT-1:0]         rsp_o
);

    // ==========================================================
    // Stage nets
    // ==========================================================
    port_map_t [NUM_WRPORT-1:0]           wr_map;
    logic [NUM_RDPORT-1:0]                rd_src;
    logic [NUM_RDPORT-1:0]                rd_cfg_ok;
    logic [NUM_WRPORT-1:0]                hwm_clr;
    logic [NUM_RDPORT-1:0]                credit_ok;
    logic [NUM_PORT-1:0][BANK_IDX_W-1:0]  port_bank;
    logic [NUM_PORT-1:0]                  port_req;
    logic [NUM_PORT-1:0]                  port_grant;
    logic [NUM_WRPORT-1:0][ROW_W-1:0]     wr_row;
    logic [NUM_RDPORT-1:0][ROW_W-1:0]     rd_row;
    logic [NUM_WRPORT-1:0][DATA_W-1:0]    wr_data;
    logic [NUM_RDPORT-1:0]                bank_rsp_valid;
    logic [NUM_RDPORT-1:0][DATA_W-1:0]    bank_rsp_data;

    wire [NUM_WRPORT-1:0] wr_fire = wr_valid_i & wr_ready_o;
    wire [NUM_RDPORT-1:0] rd_fire = rd_valid_i & rd_ready_o;

    for (genvar w = 0; w < NUM_WRPORT; w++) begin : g_wr_data
        assign wr_data[w] = wr_req_i[w].data;
    end

    glb_cfg_regs u_cfg_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_valid_i (cfg_valid_i),
        .cfg_ready_o (cfg_ready_o),
        .cfg_req_i   (cfg_req_i),
        .wr_map_o    (wr_map),
        .rd_src_o    (rd_src),
        .rd_cfg_ok_o (rd_cfg_ok),
        .hwm_clr_o   (hwm_clr)
    );

    glb_addr_map u_addr_map (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_valid_i   (wr_valid_i),
        .wr_req_i     (wr_req_i),
        .wr_ready_o   (wr_ready_o),
        .rd_valid_i   (rd_valid_i),
        .rd_req_i     (rd_req_i),
        .rd_ready_o   (rd_ready_o),
        .wr_map_i     (wr_map),
        .rd_src_i     (rd_src),
        .rd_cfg_ok_i  (rd_cfg_ok),
        .hwm_clr_i    (hwm_clr),
        .credit_ok_i  (credit_ok),
        .port_bank_o  (port_bank),
        .port_req_o   (port_req),
        .port_grant_i (port_grant),
        .wr_row_o     (wr_row),
        .rd_row_o     (rd_row)
    );

    glb_bank_arb u_bank_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .port_bank_i  (port_bank),
        .port_req_i   (port_req),
        .port_grant_o (port_grant),
        .wr_row_i     (wr_row),
        .rd_row_i     (rd_row),
        .wr_data_i    (wr_data),
        .rd_fire_i    (rd_fire),
        .wr_fire_i    (wr_fire),
        .rsp_valid_o  (bank_rsp_valid),
        .rsp_data_o   (bank_rsp_data)
    );

    glb_rd_return u_rd_return (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_fire_i   (rd_fire),
        .in_valid_i  (bank_rsp_valid),
        .in_data_i   (bank_rsp_data),
        .credit_ok_o (credit_ok),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

endmodule

`default_nettype wire

//--- dv/glb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module glb_tb
    import glb_cfg_pkg::*;
    import glb_port_pkg::*;
();

    localparam int SEED    = 95373;
    localparam int TIMEOUT = 100;

    logic                            clk;
    logic                            rst_n;
    logic                            cfg_valid_i;
    logic                            cfg_ready_o;
    cfg_req_t                        cfg_req_i;
    logic    [NUM_WRPORT-1:0]        wr_valid_i;
    logic    [NUM_WRPORT-1:0]        wr_ready_o;
    wr_req_t [NUM_WRPORT-1:0]        wr_req_i;
    logic    [NUM_RDPORT-1:0]        rd_valid_i;
    logic    [NUM_RDPORT-1:0]        rd_ready_o;
    rd_req_t [NUM_RDPORT-1:0]        rd_req_i;
    logic    [NUM_RDPORT-1:0]        rsp_valid_o;
    logic    [NUM_RDPORT-1:0]        rsp_ready_i;
    rd_rsp_t [NUM_RDPORT-1:0]        rsp_o;

    // Reference model of the bank array and of the port maps
    logic [DATA_W-1:0] ref_mem [NUM_BANK][BANK_WORDS];
    int                map_first [NUM_WRPORT];
    int                map_cnt [NUM_WRPORT];
    int                rd_src_ref [NUM_RDPORT];

    glb_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_valid_i (cfg_valid_i),
        .cfg_ready_o (cfg_ready_o),
        .cfg_req_i   (cfg_req_i),
        .wr_valid_i  (wr_valid_i),
        .wr_ready_o  (wr_ready_o),
        .wr_req_i    (wr_req_i),
        .rd_valid_i  (rd_valid_i),
        .rd_ready_o  (rd_ready_o),
        .rd_req_i    (rd_req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    always #5 clk = ~clk;

    // ==========================================================
    // Failure reporting and compare tasks
    // ==========================================================
    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rsp(input rd_rsp_t got, input rd_rsp_t exp, input string what);
        if (got !== exp) begin
            stop_fail($sformatf("ERR @%0t: %s data got %08h exp %08h",
                                $time, what, got.data, exp.data));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_fail($sformatf("ERR @%0t: %s got %0b exp %0b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_fail($sformatf("ERR @%0t: %s got %0d exp %0d", $time, what, got, exp));
        end
    endtask

    // ==========================================================
    // Reference mapping, bank = first + wrapped / 16
    // ==========================================================
    function automatic void locate(input int w, input int addr, output int bank, output int row);
        int wrapped;
        wrapped = addr % (map_cnt[w] * BANK_WORDS);
        bank    = map_first[w] + wrapped / BANK_WORDS;
        row     = wrapped % BANK_WORDS;
    endfunction

    function automatic logic [DATA_W-1:0] ref_read(input int w, input int addr);
        int bank;
        int row;
        locate(w, addr, bank, row);
        return ref_mem[bank][row];
    endfunction

    // ==========================================================
    // Drivers, all leave the time at 1 ns after a rising edge
    // ==========================================================
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic send_cfg(input cfg_req_t req);
        int n;
        n           = 0;
        cfg_valid_i = 1'b1;
        cfg_req_i   = req;
        @(negedge clk);
        while (!cfg_ready_o) begin
            n++;
            if (n > TIMEOUT) begin
                stop_fail("Timeout: configuration was never accepted");
            end
            @(negedge clk);
        end
        step();
        cfg_valid_i = 1'b0;
    endtask

    task automatic config_wr(input int w, input bank_mask_t mask);
        cfg_req_t req;
        int       b;
        req.port        = PORT_IDX_W'(w);
        req.cfg.wr.mask = mask;
        send_cfg(req);
        b = 0;
        while (b < NUM_BANK - 1 && !mask[b]) begin
            b++;
        end
        map_first[w] = b;
        map_cnt[w]   = $countones(mask);
    endtask

    task automatic config_rd(input int r, input logic src);
        cfg_req_t req;
        req.port         = PORT_IDX_W'(NUM_WRPORT + r);
        req.cfg.rd.src   = src;
        req.cfg.rd.spare = '0;
        send_cfg(req);
        rd_src_ref[r] = int'(src);
    endtask

    // Waits for the write in wr_req_i to be taken, then updates the model
    task automatic wait_wr_accept(input int w);
        int n;
        int bank;
        int row;
        n = 0;
        @(negedge clk);
        while (!wr_ready_o[w]) begin
            n++;
            if (n > TIMEOUT) begin
                stop_fail($sformatf("Timeout: write port %0d request never accepted", w));
            end
            @(negedge clk);
        end
        step();
        wr_valid_i[w] = 1'b0;
        locate(w, int'(wr_req_i[w].addr), bank, row);
        ref_mem[bank][row] = wr_req_i[w].data;
    endtask

    task automatic write_word(input int w, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data);
        wr_req_i[w].addr = addr;
        wr_req_i[w].data = data;
        wr_valid_i[w]    = 1'b1;
        wait_wr_accept(w);
    endtask

    task automatic wait_rd_accept(input int r);
        int n;
        n = 0;
        @(negedge clk);
        while (!rd_ready_o[r]) begin
            n++;
            if (n > TIMEOUT) begin
                stop_fail($sformatf("Timeout: read port %0d request never accepted", r));
            end
            @(negedge clk);
        end
        step();
        rd_valid_i[r] = 1'b0;
    endtask

    task automatic issue_read(input int r, input logic [ADDR_W-1:0] addr);
        rd_req_i[r].addr = addr;
        rd_valid_i[r]    = 1'b1;
        wait_rd_accept(r);
    endtask

    // Takes one response off a read port and compares it
    task automatic expect_rsp(input int r, input logic [DATA_W-1:0] value);
        rd_rsp_t exp;
        int      n;
        exp.data = value;
        n        = 0;
        @(negedge clk);
        while (!rsp_valid_o[r]) begin
            n++;
            if (n > TIMEOUT) begin
                stop_fail($sformatf("Timeout: no response on read port %0d", r));
            end
            @(negedge clk);
        end
        check_rsp(rsp_o[r], exp, $sformatf("read port %0d response", r));
        step();
        rsp_ready_i[r] = 1'b1;
        step();
        rsp_ready_i[r] = 1'b0;
    endtask

    task automatic read_check(input int r, input int addr);
        logic [DATA_W-1:0] exp;
        exp = ref_read(rd_src_ref[r], addr);
        issue_read(r, ADDR_W'(addr));
        expect_rsp(r, exp);
    endtask

    task automatic expect_blocked(input int r, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_ready(rd_ready_o[r], 1'b0, "read above high-water mark ready");
        end
        step();
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic test_mapping();
        config_wr(0, 8'h03);
        config_wr(1, 8'hF0);
        config_rd(0, 1'b0);
        config_rd(1, 1'b1);
        for (int a = 0; a < 32; a++) begin
            write_word(0, ADDR_W'(a), $urandom());
        end
        for (int a = 0; a < 64; a++) begin
            write_word(1, ADDR_W'(a), $urandom());
        end
        for (int a = 0; a < 32; a++) begin
            read_check(0, a);
        end
        for (int a = 0; a < 64; a++) begin
            read_check(1, a);
        end
    endtask

    task automatic test_wrap();
        logic [DATA_W-1:0] d;
        d = $urandom();
        // Range of 32, so address 40 lands on 8
        write_word(0, 7'd40, d);
        issue_read(0, 7'd8);
        expect_rsp(0, d);
    endtask

    task automatic test_ordering();
        logic [DATA_W-1:0] d;
        d = $urandom();
        config_wr(0, 8'h03);
        rd_req_i[0].addr = 7'd5;
        rd_valid_i[0]    = 1'b1;
        expect_blocked(0, 20);
        write_word(0, 7'd5, d);
        wait_rd_accept(0);
        expect_rsp(0, d);
        // Fresh configuration empties the mark again
        config_wr(0, 8'h03);
        rd_req_i[0].addr = 7'd0;
        rd_valid_i[0]    = 1'b1;
        expect_blocked(0, 20);
        rd_valid_i[0] = 1'b0;
    endtask

    task automatic test_conflict();
        logic [DATA_W-1:0] old_val;
        config_wr(0, 8'h10);
        write_word(0, 7'd2, $urandom());
        read_check(1, 2);
        old_val          = ref_read(1, 3);
        rd_req_i[1].addr = 7'd3;
        rd_valid_i[1]    = 1'b1;
        wr_req_i[1].addr = 7'd7;
        wr_req_i[1].data = $urandom();
        wr_valid_i[1]    = 1'b1;
        @(negedge clk);
        check_ready(rd_ready_o[1], 1'b1, "bank 4 read grant");
        check_ready(wr_ready_o[1], 1'b0, "bank 4 write grant");
        step();
        rd_valid_i[1] = 1'b0;
        wait_wr_accept(1);
        expect_rsp(1, old_val);
        read_check(1, 7);
    endtask

    task automatic test_backpressure();
        logic [DATA_W-1:0] exp_q [$];
        logic              got;
        int                acc;
        acc              = 0;
        rd_req_i[1].addr = '0;
        rd_valid_i[1]    = 1'b1;
        repeat (20) begin
            @(negedge clk);
            got = rd_ready_o[1];
            step();
            if (got) begin
                exp_q.push_back(ref_read(1, acc));
                acc++;
                rd_req_i[1].addr = ADDR_W'(acc);
            end
        end
        rd_valid_i[1] = 1'b0;
        check_count(acc, 2, "reads accepted with responses stalled");
        while (exp_q.size() > 0) begin
            expect_rsp(1, exp_q.pop_front());
        end
        for (int a = 2; a < 6; a++) begin
            read_check(1, a);
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        @(negedge clk);
        check_ready(cfg_ready_o, 1'b1, "cfg_ready_o after reset");
        for (int i = 0; i < NUM_WRPORT; i++) begin
            check_ready(wr_ready_o[i], 1'b0, "wr_ready_o after reset");
        end
        for (int i = 0; i < NUM_RDPORT; i++) begin
            check_ready(rd_ready_o[i], 1'b0, "rd_ready_o after reset");
            check_ready(rsp_valid_o[i], 1'b0, "rsp_valid_o after reset");
        end
        step();
        wr_req_i   = '0;
        rd_req_i   = '0;
        wr_valid_i = '1;
        rd_valid_i = '1;
        // Unconfigured ports must never take a request
        repeat (10) begin
            @(negedge clk);
            for (int i = 0; i < NUM_WRPORT; i++) begin
                check_ready(wr_ready_o[i], 1'b0, "unconfigured wr_ready_o");
            end
            for (int i = 0; i < NUM_RDPORT; i++) begin
                check_ready(rd_ready_o[i], 1'b0, "unconfigured rd_ready_o");
            end
        end
        step();
        wr_valid_i = '0;
        rd_valid_i = '0;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cfg_valid_i = 1'b0;
        cfg_req_i   = '0;
        wr_valid_i  = '0;
        wr_req_i    = '0;
        rd_valid_i  = '0;
        rd_req_i    = '0;
        rsp_ready_i = '0;
        void'($urandom(SEED));
        apply_reset();
        test_mapping();
        test_wrap();
        test_ordering();
        test_conflict();
        test_backpressure();
        test_reset_state();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hdl/glb_cfg_pkg.sv
hdl/glb_port_pkg.sv
hdl/glb_cfg_regs.sv
hdl/glb_addr_map.sv
hdl/glb_bank.sv
hdl/glb_bank_arb.sv
hdl/glb_rd_return.sv
hdl/glb_top.sv
dv/glb_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= glb_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_STR  := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
